//--- source/hp_dump_defines.svh
`ifndef HP_DUMP_DEFINES_SVH
`define HP_DUMP_DEFINES_SVH

// internal bus word address and data widths
`define HP_ADDR_W       16
`define HP_DATA_W       32

// AXI HP port byte address width
`define HP_AXI_ADDR_W   32

// word address of the dump engine register block
`define HP_SLAVE_BASE   16'h0180

// register offsets within the block
`define HP_REG_STATUS   0
`define HP_REG_START    1
`define HP_REG_WINDOW   2
`define HP_REG_DEST     3

`endif

//--- source/hp_dump_pkg.sv
`include "hp_dump_defines.svh"

package hp_dump_pkg;

    // internal bus word address and data
    typedef logic [`HP_ADDR_W-1:0] bus_addr_t;
    typedef logic [`HP_DATA_W-1:0] bus_data_t;

    // byte address on the AXI HP port
    typedef logic [`HP_AXI_ADDR_W-1:0] axi_addr_t;

    // one extra bit so a full 64k word window fits
    typedef logic [`HP_ADDR_W:0] word_count_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_READ,
        SEQ_WAIT_DATA,
        SEQ_HAND_OFF
    } seq_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDRESS_DATA,
        WR_RESPONSE
    } wr_state_t;

endpackage

//--- source/hp_reg_decode.sv
`timescale 1ns/1ns

`include "hp_dump_defines.svh"

module hp_reg_decode (
    input  logic                   bus,
    input  logic                   rst_n,
    input  hp_dump_pkg::bus_addr_t s_addr,
    input  logic                   s_wr,
    input  logic                   s_rd,
    input  hp_dump_pkg::bus_data_t s_wdata,
    input  logic                   fetch_done,
    input  logic                   write_done,
    input  logic                   resp_error,
    output hp_dump_pkg::bus_data_t s_rdata,
    output logic                   s_rvalid,
    output logic                   start,
    output hp_dump_pkg::bus_addr_t win_start,
    output hp_dump_pkg::bus_addr_t win_end,
    output hp_dump_pkg::axi_addr_t dest,
    output logic                   done
);
    import hp_dump_pkg::*;

    localparam bus_addr_t slave_base = `HP_SLAVE_BASE;

    bus_addr_t   offset;
    logic        in_block;
    logic        wr_hit;
    logic        busy;
    logic        error_flag;
    logic        fetch_seen;
    logic        last_write;
    word_count_t done_count;
    word_count_t dump_len;

    // addresses below the base wrap to a large offset
    assign offset   = s_addr - slave_base;
    assign in_block = (offset < bus_addr_t'(4));
    assign wr_hit   = s_wr && in_block;

    // only a valid window starts a dump, and only while idle
    assign start = wr_hit && (offset == bus_addr_t'(`HP_REG_START)) && s_wdata[0]
                   && !busy && (win_end >= win_start);

    // final response of the dump, all reads already handed off
    assign last_write = write_done && fetch_seen
                        && ((done_count + word_count_t'(1)) == dump_len);

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            win_start <= '0;
            win_end   <= '0;
            dest      <= '0;
        end else if (wr_hit) begin
            if (offset == bus_addr_t'(`HP_REG_WINDOW)) begin
                win_end   <= s_wdata[31:16];
                win_start <= s_wdata[15:0];
            end
            if (offset == bus_addr_t'(`HP_REG_DEST)) begin
                dest <= s_wdata;
            end
        end
    end

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            error_flag <= 1'b0;
            fetch_seen <= 1'b0;
            done_count <= '0;
            dump_len   <= '0;
            done       <= 1'b0;
        end else begin
            done <= last_write;
            if (start) begin
                busy       <= 1'b1;
                error_flag <= 1'b0;
                fetch_seen <= 1'b0;
                done_count <= '0;
                dump_len   <= {1'b0, win_end} - {1'b0, win_start} + word_count_t'(1);
            end else begin
                if (fetch_done) begin
                    fetch_seen <= 1'b1;
                end
                if (write_done) begin
                    done_count <= done_count + word_count_t'(1);
                end
                // sticky until the next start
                if (resp_error) begin
                    error_flag <= 1'b1;
                end
                if (last_write) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            s_rvalid <= 1'b0;
        end else begin
            s_rvalid <= s_rd && in_block;
        end
    end

    always_ff @(posedge bus) begin
        case (offset)
            `HP_REG_STATUS: s_rdata <= {busy, error_flag, 14'd0, done_count[15:0]};
            `HP_REG_START:  s_rdata <= {31'd0, busy};
            `HP_REG_WINDOW: s_rdata <= {win_end, win_start};
            `HP_REG_DEST:   s_rdata <= dest;
            default:        s_rdata <= '0;
        endcase
    end

    // no second start until the running dump reports done
    a_no_restart: assert property (@(posedge bus) disable iff (!rst_n)
        start |=> !start until done);

endmodule

//--- source/hp_read_sequencer.sv
`timescale 1ns/1ns

module hp_read_sequencer (
    input  logic                     bus,
    input  logic                     rst_n,
    input  logic                     start,
    input  hp_dump_pkg::bus_addr_t   win_start,
    input  hp_dump_pkg::bus_addr_t   win_end,
    input  hp_dump_pkg::bus_data_t   m_rdata,
    input  logic                     m_rvalid,
    input  logic                     writer_busy,
    output hp_dump_pkg::bus_addr_t   m_addr,
    output logic                     m_rd,
    output logic                     word_strobe,
    output hp_dump_pkg::bus_data_t   word_data,
    output hp_dump_pkg::word_count_t word_index,
    output logic                     fetch_done
);
    import hp_dump_pkg::*;

    seq_state_t  state;
    bus_addr_t   cur_addr;
    bus_addr_t   end_addr;
    word_count_t fetch_idx;
    bus_data_t   hold_data;
    word_count_t hold_index;
    logic        last_word;

    assign m_rd        = (state == SEQ_READ);
    assign m_addr      = cur_addr;
    assign last_word   = (cur_addr == end_addr);
    // held word goes out as soon as the writer is free
    assign word_strobe = (state == SEQ_HAND_OFF) && !writer_busy;
    assign word_data   = hold_data;
    assign word_index  = hold_index;

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            state      <= SEQ_IDLE;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= word_strobe && last_word;
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state <= SEQ_READ;
                    end
                end
                SEQ_READ: begin
                    state <= SEQ_WAIT_DATA;
                end
                SEQ_WAIT_DATA: begin
                    if (m_rvalid) begin
                        state <= SEQ_HAND_OFF;
                    end
                end
                SEQ_HAND_OFF: begin
                    if (!writer_busy) begin
                        state <= last_word ? SEQ_IDLE : SEQ_READ;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // window walk and fetched word
    always_ff @(posedge bus) begin
        if (state == SEQ_IDLE && start) begin
            cur_addr  <= win_start;
            end_addr  <= win_end;
            fetch_idx <= '0;
        end else if (word_strobe && !last_word) begin
            cur_addr  <= cur_addr + bus_addr_t'(1);
            fetch_idx <= fetch_idx + word_count_t'(1);
        end
        if (state == SEQ_WAIT_DATA && m_rvalid) begin
            hold_data  <= m_rdata;
            hold_index <= fetch_idx;
        end
    end

    // single outstanding read on the master port
    a_one_read: assert property (@(posedge bus) disable iff (!rst_n)
        m_rd |=> !m_rd until m_rvalid);

endmodule

//--- source/hp_axi_writer.sv
`timescale 1ns/1ns

`include "hp_dump_defines.svh"

module hp_axi_writer (
    input  logic                     bus,
    input  logic                     rst_n,
    input  hp_dump_pkg::axi_addr_t   dest,
    input  logic                     word_strobe,
    input  hp_dump_pkg::bus_data_t   word_data,
    input  hp_dump_pkg::word_count_t word_index,
    input  logic                     awready,
    input  logic                     wready,
    input  logic [1:0]               bresp,
    input  logic                     bvalid,
    output hp_dump_pkg::axi_addr_t   awaddr,
    output logic                     awvalid,
    output hp_dump_pkg::bus_data_t   wdata,
    output logic [`HP_DATA_W/8-1:0]  wstrb,
    output logic                     wlast,
    output logic                     wvalid,
    output logic                     bready,
    output logic                     writer_busy,
    output logic                     write_done,
    output logic                     resp_error
);
    import hp_dump_pkg::*;

    wr_state_t state;
    logic      aw_clear;
    logic      w_clear;

    // single beat, full word writes
    assign wstrb = '1;
    assign wlast = 1'b1;

    assign bready      = (state == WR_RESPONSE);
    assign writer_busy = (state != WR_IDLE);
    assign write_done  = (state == WR_RESPONSE) && bvalid;
    // slverr and decerr are only flagged
    assign resp_error  = write_done && (bresp != 2'b00);

    // channel done once accepted now or earlier
    assign aw_clear = !awvalid || awready;
    assign w_clear  = !wvalid || wready;

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            state   <= WR_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (word_strobe) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= WR_ADDRESS_DATA;
                    end
                end
                WR_ADDRESS_DATA: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (aw_clear && w_clear) begin
                        state <= WR_RESPONSE;
                    end
                end
                WR_RESPONSE: begin
                    if (bvalid) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // consecutive 32-bit words from the destination
    always_ff @(posedge bus) begin
        if (state == WR_IDLE && word_strobe) begin
            awaddr <= dest + (axi_addr_t'(word_index) << 2);
            wdata  <= word_data;
        end
    end

    a_aw_hold: assert property (@(posedge bus) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr));

    a_w_hold: assert property (@(posedge bus) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata));

endmodule

//--- source/hp_dump_top.sv
`timescale 1ns/1ns

`include "hp_dump_defines.svh"

module hp_dump_top (
    input  logic                    bus,
    input  logic                    rst_n,
    // register slave port
    input  hp_dump_pkg::bus_addr_t  s_addr,
    input  logic                    s_wr,
    input  logic                    s_rd,
    input  hp_dump_pkg::bus_data_t  s_wdata,
    output hp_dump_pkg::bus_data_t  s_rdata,
    output logic                    s_rvalid,
    // internal bus master port
    output hp_dump_pkg::bus_addr_t  m_addr,
    output logic                    m_rd,
    input  hp_dump_pkg::bus_data_t  m_rdata,
    input  logic                    m_rvalid,
    // AXI HP write channels
    output hp_dump_pkg::axi_addr_t  awaddr,
    output logic                    awvalid,
    input  logic                    awready,
    output hp_dump_pkg::bus_data_t  wdata,
    output logic [`HP_DATA_W/8-1:0] wstrb,
    output logic                    wlast,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic [1:0]              bresp,
    input  logic                    bvalid,
    output logic                    bready,
    output logic                    done
);
    import hp_dump_pkg::*;

    logic        start;
    bus_addr_t   win_start;
    bus_addr_t   win_end;
    axi_addr_t   dest;
    logic        fetch_done;
    logic        write_done;
    logic        resp_error;
    logic        writer_busy;
    logic        word_strobe;
    bus_data_t   word_data;
    word_count_t word_index;

    hp_reg_decode hp_reg_decode_i (
        .bus        (bus),
        .rst_n      (rst_n),
        .s_addr     (s_addr),
        .s_wr       (s_wr),
        .s_rd       (s_rd),
        .s_wdata    (s_wdata),
        .fetch_done (fetch_done),
        .write_done (write_done),
        .resp_error (resp_error),
        .s_rdata    (s_rdata),
        .s_rvalid   (s_rvalid),
        .start      (start),
        .win_start  (win_start),
        .win_end    (win_end),
        .dest       (dest),
        .done       (done)
    );

    hp_read_sequencer hp_read_sequencer_i (
        .bus         (bus),
        .rst_n       (rst_n),
        .start       (start),
        .win_start   (win_start),
        .win_end     (win_end),
        .m_rdata     (m_rdata),
        .m_rvalid    (m_rvalid),
        .writer_busy (writer_busy),
        .m_addr      (m_addr),
        .m_rd        (m_rd),
        .word_strobe (word_strobe),
        .word_data   (word_data),
        .word_index  (word_index),
        .fetch_done  (fetch_done)
    );

    hp_axi_writer hp_axi_writer_i (
        .bus         (bus),
        .rst_n       (rst_n),
        .dest        (dest),
        .word_strobe (word_strobe),
        .word_data   (word_data),
        .word_index  (word_index),
        .awready     (awready),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .bready      (bready),
        .writer_busy (writer_busy),
        .write_done  (write_done),
        .resp_error  (resp_error)
    );

endmodule

//--- verification/hp_dump_tasks.svh
// expected memory contents for a word address
function automatic bus_data_t mem_rule(input bus_addr_t a);
    return (bus_data_t'(a) * 32'h0000_9e37) ^ 32'h5a5a_0000;
endfunction

task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error: %s is %h, expected %h", name, got, exp);
    end
endtask

task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error: %s is %h, expected %h", name, got, exp);
    end
endtask

task automatic check_count(input string name, input word_count_t got, input word_count_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error: %s is %h, expected %h", name, got, exp);
    end
endtask

// one write strobe at an offset from the block base
task automatic reg_write(input int offset, input bus_data_t data);
    s_addr  = bus_addr_t'(`HP_SLAVE_BASE + offset);
    s_wdata = data;
    s_wr    = 1'b1;
    @(posedge bus);
    #1;
    s_wr = 1'b0;
endtask

task automatic reg_read(input bus_addr_t addr, output bus_data_t data, output bit seen,
                        output int cycles);
    int n;
    s_addr = addr;
    s_rd   = 1'b1;
    @(posedge bus);
    #1;
    s_rd = 1'b0;
    seen = 1'b0;
    data = '0;
    n    = 0;
    while (!seen && n < 4) begin
        @(negedge bus);
        if (s_rvalid === 1'b1) begin
            seen = 1'b1;
            data = s_rdata;
        end
        @(posedge bus);
        #1;
        n++;
    end
    cycles = n;
endtask

task automatic read_check(input int offset, input bus_data_t exp, input string name);
    bus_data_t got;
    bit        seen;
    int        cycles;
    reg_read(bus_addr_t'(`HP_SLAVE_BASE + offset), got, seen, cycles);
    if (!seen) begin
        errors++;
        $display("register read of %s got no rvalid within 4 cycles", name);
    end else begin
        if (cycles != 1) begin
            errors++;
            $display("register read of %s returned rvalid after %0d cycles instead of 1",
                     name, cycles);
        end
        check_data(name, got, exp);
    end
endtask

task automatic wait_done(input int max_cycles, output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < max_cycles) begin
        @(negedge bus);
        if (done === 1'b1) begin
            seen = 1'b1;
        end
        @(posedge bus);
        #1;
        n++;
    end
endtask

task automatic start_dump(input bus_addr_t first, input int len, input axi_addr_t base);
    addr_q.delete();
    data_q.delete();
    done_pulses = 0;
    reg_write(`HP_REG_WINDOW, {first + bus_addr_t'(len - 1), first});
    reg_write(`HP_REG_DEST, base);
    reg_write(`HP_REG_START, 32'h1);
endtask

task automatic finish_dump(input bus_addr_t first, input int len, input axi_addr_t base,
                           input bit exp_err);
    bit seen;
    wait_done(5000, seen);
    if (!seen) begin
        errors++;
        $display("dump of %0d words from %h gave no done within 5000 cycles", len, first);
    end
    // room for a stray second done pulse
    repeat (4) begin
        @(posedge bus);
        #1;
    end
    check_count("done pulses", word_count_t'(done_pulses), word_count_t'(1));
    check_count("axi writes", word_count_t'(addr_q.size()), word_count_t'(len));
    for (int k = 0; k < addr_q.size() && k < len; k++) begin
        check_addr("awaddr", addr_q[k], base + axi_addr_t'(4 * k));
        check_data("wdata", data_q[k], mem_rule(first + bus_addr_t'(k)));
    end
    read_check(`HP_REG_STATUS, {1'b0, exp_err, 14'd0, bus_addr_t'(len)}, "status");
endtask

task automatic test_after_reset();
    read_check(`HP_REG_STATUS, 32'h0, "status");
    check_count("axi valid cycles", word_count_t'(valid_cycles), word_count_t'(0));
endtask

task automatic test_readback();
    bus_data_t got;
    bit        seen;
    int        cycles;
    reg_write(`HP_REG_WINDOW, 32'h0123_0045);
    reg_write(`HP_REG_DEST, 32'h8000_1000);
    read_check(`HP_REG_WINDOW, 32'h0123_0045, "window");
    read_check(`HP_REG_DEST, 32'h8000_1000, "dest");
    // offset 7 lies outside the four register block
    reg_write(7, 32'hdead_beef);
    read_check(`HP_REG_WINDOW, 32'h0123_0045, "window");
    read_check(`HP_REG_DEST, 32'h8000_1000, "dest");
    reg_read(bus_addr_t'(`HP_SLAVE_BASE + 7), got, seen, cycles);
    if (seen) begin
        errors++;
        $display("read outside the register block produced an rvalid");
    end
endtask

task automatic test_basic_dump();
    start_dump(16'h0040, 8, 32'h1000_0000);
    finish_dump(16'h0040, 8, 32'h1000_0000, 1'b0);
endtask

task automatic test_back_pressure();
    ready_pct   = 15;
    stall_reads = 0;
    start_dump(16'h0300, 20, 32'h2000_0000);
    finish_dump(16'h0300, 20, 32'h2000_0000, 1'b0);
    if (stall_reads == 0) begin
        errors++;
        $display("no internal bus read was issued while the AXI writer stalled");
    end
    ready_pct = 70;
endtask

task automatic test_rejected_start();
    bit        seen;
    bus_data_t got;
    int        cycles;
    start_dump(16'h1000, 16, 32'h3000_0100);
    // busy is the top bit of status
    reg_read(bus_addr_t'(`HP_SLAVE_BASE + `HP_REG_STATUS), got, seen, cycles);
    check_data("status busy bit", got & 32'h8000_0000, 32'h8000_0000);
    reg_write(`HP_REG_START, 32'h1);
    finish_dump(16'h1000, 16, 32'h3000_0100, 1'b0);
    // end below start
    addr_q.delete();
    done_pulses = 0;
    reg_write(`HP_REG_WINDOW, {16'h0010, 16'h0020});
    reg_write(`HP_REG_START, 32'h1);
    wait_done(200, seen);
    if (seen) begin
        errors++;
        $display("done pulsed for a window whose end is below its start");
    end
    check_count("axi writes", word_count_t'(addr_q.size()), word_count_t'(0));
    read_check(`HP_REG_STATUS, {2'b00, 14'd0, 16'd16}, "status");
endtask

task automatic test_error_flag();
    bresp_mode = 2'b10;
    start_dump(16'h2000, 4, 32'h4000_0000);
    finish_dump(16'h2000, 4, 32'h4000_0000, 1'b1);
    bresp_mode = 2'b00;
    start_dump(16'h2100, 4, 32'h4000_0400);
    finish_dump(16'h2100, 4, 32'h4000_0400, 1'b0);
endtask

//--- verification/hp_dump_tb.sv
`timescale 1ns/1ns

`include "hp_dump_defines.svh"

module hp_dump_tb;
    import hp_dump_pkg::*;

    logic        bus;
    logic        rst_n;
    bus_addr_t   s_addr;
    logic        s_wr;
    logic        s_rd;
    bus_data_t   s_wdata;
    bus_data_t   s_rdata;
    logic        s_rvalid;
    bus_addr_t   m_addr;
    logic        m_rd;
    bus_data_t   m_rdata;
    logic        m_rvalid;
    axi_addr_t   awaddr;
    logic        awvalid;
    logic        awready;
    bus_data_t   wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic        done;

    integer      seed;
    int          errors;
    int          checks;
    bus_data_t   mem [0:65535];

    // memory model state
    logic        rd_seen;
    logic        rd_pending;
    bus_addr_t   rd_req;
    bus_addr_t   rd_addr;
    int          rd_delay;
    int          stall_reads;

    // AXI slave model state
    int          ready_pct;
    logic [1:0]  bresp_mode;
    logic        aw_fire;
    logic        w_fire;
    logic        b_fire;
    logic        aw_held;
    logic        w_held;
    axi_addr_t   aw_value;
    axi_addr_t   aw_keep;
    bus_data_t   w_value;
    bus_data_t   w_keep;
    axi_addr_t   addr_q[$];
    bus_data_t   data_q[$];
    int          valid_cycles;
    int          done_pulses;

    hp_dump_top hp_dump_top_i (
        .bus      (bus),
        .rst_n    (rst_n),
        .s_addr   (s_addr),
        .s_wr     (s_wr),
        .s_rd     (s_rd),
        .s_wdata  (s_wdata),
        .s_rdata  (s_rdata),
        .s_rvalid (s_rvalid),
        .m_addr   (m_addr),
        .m_rd     (m_rd),
        .m_rdata  (m_rdata),
        .m_rvalid (m_rvalid),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wlast    (wlast),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .done     (done)
    );

    `include "hp_dump_tasks.svh"

    initial begin
        bus = 1'b0;
        forever begin
            #4 bus = ~bus;
        end
    end

    // internal bus memory, 0 to 3 cycles of read latency
    always begin
        @(negedge bus);
        rd_seen = (m_rd === 1'b1);
        rd_req  = m_addr;
        // a read issued while the AXI address channel stalls
        if (m_rd === 1'b1 && awvalid === 1'b1 && awready === 1'b0) begin
            stall_reads++;
        end
        @(posedge bus);
        #1;
        m_rvalid = 1'b0;
        if (rd_seen) begin
            rd_pending = 1'b1;
            rd_addr    = rd_req;
            rd_delay   = $unsigned($random(seed)) % 4;
        end
        if (rd_pending) begin
            if (rd_delay == 0) begin
                m_rvalid   = 1'b1;
                m_rdata    = mem[rd_addr];
                rd_pending = 1'b0;
            end else begin
                rd_delay--;
            end
        end
    end

    // AXI slave, address and data may arrive in either order
    always begin
        @(negedge bus);
        aw_fire  = (awvalid === 1'b1) && awready;
        w_fire   = (wvalid === 1'b1) && wready;
        b_fire   = bvalid && (bready === 1'b1);
        aw_value = awaddr;
        w_value  = wdata;
        if (awvalid === 1'b1 || wvalid === 1'b1) begin
            valid_cycles++;
        end
        if (w_fire && (wstrb !== 4'hf || wlast !== 1'b1)) begin
            errors++;
            $display("** Error: wstrb %h wlast %h on a write beat", wstrb, wlast);
        end
        if (done === 1'b1) begin
            done_pulses++;
        end
        @(posedge bus);
        #1;
        if (aw_fire) begin
            aw_held = 1'b1;
            aw_keep = aw_value;
        end
        if (w_fire) begin
            w_held = 1'b1;
            w_keep = w_value;
        end
        if (b_fire) begin
            bvalid = 1'b0;
        end
        if (aw_held && w_held) begin
            addr_q.push_back(aw_keep);
            data_q.push_back(w_keep);
            aw_held = 1'b0;
            w_held  = 1'b0;
            bvalid  = 1'b1;
            bresp   = bresp_mode;
        end
        awready = ($unsigned($random(seed)) % 100) < ready_pct;
        wready  = ($unsigned($random(seed)) % 100) < ready_pct;
    end

    initial begin
        seed         = 32'h1f40;
        errors       = 0;
        checks       = 0;
        rst_n        = 1'b0;
        s_addr       = '0;
        s_wr         = 1'b0;
        s_rd         = 1'b0;
        s_wdata      = '0;
        m_rdata      = '0;
        m_rvalid     = 1'b0;
        awready      = 1'b0;
        wready       = 1'b0;
        bresp        = 2'b00;
        bvalid       = 1'b0;
        rd_pending   = 1'b0;
        stall_reads  = 0;
        ready_pct    = 70;
        bresp_mode   = 2'b00;
        aw_held      = 1'b0;
        w_held       = 1'b0;
        valid_cycles = 0;
        done_pulses  = 0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = mem_rule(bus_addr_t'(i));
        end
        repeat (8) @(posedge bus);
        #1;
        rst_n = 1'b1;

        test_after_reset();
        test_readback();
        test_basic_dump();
        test_back_pressure();
        test_rejected_start();
        test_error_flag();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+source
+incdir+verification
source/hp_dump_pkg.sv
source/hp_reg_decode.sv
source/hp_read_sequencer.sv
source/hp_axi_writer.sv
source/hp_dump_top.sv
verification/hp_dump_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= hp_dump_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
